//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := elevator_display_tb
FILELIST  := elevator_display.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- elevator_display.f
+incdir+include
source/elevator_display_pkg.sv
source/facade_painter.sv
source/shaft_painter.sv
source/scene_compositor.sv
source/elevator_display.sv
tb/elevator_display_tb.sv

//--- source/elevator_display.sv
`timescale 1ns/10ps

module elevator_display (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           enable,
    input  elevator_display_pkg::coord_t   x_coord,
    input  elevator_display_pkg::coord_t   y_coord,
    input  logic [7:0]                     destination,
    input  logic [1:0]                     sim_state,
    output elevator_display_pkg::channel_t r,
    output elevator_display_pkg::channel_t g,
    output elevator_display_pkg::channel_t b
);
    import elevator_display_pkg::*;

    car_pos_t   left_car_pos;
    car_pos_t   right_car_pos;
    sim_state_e draw_state;
    logic       left_facade_hit;
    rgb_t       left_facade_rgb;
    logic       left_shaft_hit;
    rgb_t       left_shaft_rgb;
    logic       right_shaft_hit;
    rgb_t       right_shaft_rgb;
    logic       right_facade_hit;
    rgb_t       right_facade_rgb;

    // Upper nibble is the left car
    assign left_car_pos  = destination[7:4];
    assign right_car_pos = destination[3:0];
    assign draw_state    = sim_state_e'(sim_state);

    facade_painter #(.X_LO(SIDE_MARGIN), .X_HI(LEFT_FACADE_END)) u_left_facade (
        .x_coord (x_coord),
        .y_coord (y_coord),
        .hit     (left_facade_hit),
        .rgb     (left_facade_rgb)
    );

    shaft_painter #(.X_LO(LEFT_SHAFT_LO), .X_HI(LEFT_SHAFT_HI)) u_left_shaft (
        .x_coord (x_coord),
        .y_coord (y_coord),
        .car_pos (left_car_pos),
        .state   (draw_state),
        .hit     (left_shaft_hit),
        .rgb     (left_shaft_rgb)
    );

    shaft_painter #(.X_LO(RIGHT_SHAFT_LO), .X_HI(RIGHT_SHAFT_HI)) u_right_shaft (
        .x_coord (x_coord),
        .y_coord (y_coord),
        .car_pos (right_car_pos),
        .state   (draw_state),
        .hit     (right_shaft_hit),
        .rgb     (right_shaft_rgb)
    );

    facade_painter #(.X_LO(RIGHT_FACADE_LO), .X_HI(RIGHT_FACADE_HI)) u_right_facade (
        .x_coord (x_coord),
        .y_coord (y_coord),
        .hit     (right_facade_hit),
        .rgb     (right_facade_rgb)
    );

    scene_compositor u_compositor (
        .clk              (clk),
        .rst_n            (rst_n),
        .enable           (enable),
        .x_coord          (x_coord),
        .y_coord          (y_coord),
        .left_facade_hit  (left_facade_hit),
        .left_facade_rgb  (left_facade_rgb),
        .left_shaft_hit   (left_shaft_hit),
        .left_shaft_rgb   (left_shaft_rgb),
        .right_shaft_hit  (right_shaft_hit),
        .right_shaft_rgb  (right_shaft_rgb),
        .right_facade_hit (right_facade_hit),
        .right_facade_rgb (right_facade_rgb),
        .r                (r),
        .g                (g),
        .b                (b)
    );

endmodule

//--- source/elevator_display_pkg.sv
package elevator_display_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [3:0]  channel_t;
    // {red, green, blue}
    typedef logic [11:0] rgb_t;
    // Half-floor steps above the first floor
    typedef logic [3:0]  car_pos_t;

    typedef enum logic [1:0] {
        ST_PARKED  = 2'd0,
        ST_MOVING  = 2'd1,
        ST_STOPPED = 2'd2
    } sim_state_e;

    localparam coord_t H_ACTIVE     = 10'd640;
    localparam coord_t V_ACTIVE     = 10'd480;
    localparam coord_t SIDE_MARGIN  = 10'd20;
    localparam coord_t TOP_MARGIN   = 10'd15;
    localparam coord_t FLOOR_HEIGHT = 10'd75;
    localparam coord_t GROUND_ROW   = V_ACTIVE - TOP_MARGIN;

    // Column windows, low bound inclusive and high bound exclusive
    localparam coord_t LEFT_FACADE_END   = 10'd210;
    localparam coord_t LEFT_OUTLINE_LO   = 10'd195;
    localparam coord_t LEFT_OUTLINE_HI   = 10'd205;
    localparam coord_t LEFT_SHAFT_LO     = 10'd205;
    localparam coord_t LEFT_SHAFT_HI     = 10'd295;
    localparam coord_t MID_OUTLINE_LO    = 10'd295;
    localparam coord_t MID_OUTLINE_HI    = 10'd305;
    localparam coord_t RIGHT_SHAFT_LO    = 10'd305;
    localparam coord_t RIGHT_SHAFT_HI    = 10'd395;
    localparam coord_t RIGHT_OUTLINE_LO  = 10'd395;
    localparam coord_t RIGHT_OUTLINE_HI  = 10'd405;
    localparam coord_t RIGHT_FACADE_LO   = 10'd405;
    localparam coord_t RIGHT_FACADE_HI   = H_ACTIVE - SIDE_MARGIN;

    localparam coord_t   PARKED_CAR_HEIGHT   = 10'd70;
    localparam coord_t   CAR_HEIGHT          = 10'd75;
    localparam coord_t   FIRST_FLOOR_CAR_TOP = 10'd390;
    localparam car_pos_t MAX_CAR_POS         = 4'd10;

    localparam coord_t STOP_X_LO = 10'd300;
    localparam coord_t STOP_X_HI = 10'd340;
    localparam coord_t STOP_Y_LO = 10'd200;
    localparam coord_t STOP_Y_HI = 10'd260;

    localparam rgb_t BLACK_RGB       = 12'h000;
    localparam rgb_t SKY_RGB         = 12'h28F;
    localparam rgb_t GRASS_RGB       = 12'h0F0;
    localparam rgb_t FLOOR_DARK_RGB  = 12'h9AA;
    localparam rgb_t FLOOR_LIGHT_RGB = 12'hBBB;
    localparam rgb_t OUTLINE_RGB     = BLACK_RGB;
    localparam rgb_t SHAFT_RGB       = 12'h841;
    localparam rgb_t CAR_RGB         = 12'h444;
    localparam rgb_t STOP_RGB        = 12'hF00;

endpackage

//--- source/facade_painter.sv
`timescale 1ns/10ps

module facade_painter #(
    parameter elevator_display_pkg::coord_t X_LO = 10'd0,
    parameter elevator_display_pkg::coord_t X_HI = 10'd0
) (
    input  elevator_display_pkg::coord_t x_coord,
    input  elevator_display_pkg::coord_t y_coord,
    output logic                         hit,
    output elevator_display_pkg::rgb_t   rgb
);
    import elevator_display_pkg::*;

    coord_t floor_band;

    // Full height, the sky above is drawn first
    assign hit = (x_coord >= X_LO) && (x_coord < X_HI);

    // Band 0 is the sixth floor
    assign floor_band = (y_coord - TOP_MARGIN) / FLOOR_HEIGHT;

    always_comb begin
        case (floor_band)
            10'd0, 10'd2, 10'd4: begin
                rgb = FLOOR_DARK_RGB;
            end
            // Odd floors and everything below the ground line
            default: begin
                rgb = FLOOR_LIGHT_RGB;
            end
        endcase
    end

endmodule

//--- source/scene_compositor.sv
`timescale 1ns/10ps

module scene_compositor (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           enable,
    input  elevator_display_pkg::coord_t   x_coord,
    input  elevator_display_pkg::coord_t   y_coord,
    input  logic                           left_facade_hit,
    input  elevator_display_pkg::rgb_t     left_facade_rgb,
    input  logic                           left_shaft_hit,
    input  elevator_display_pkg::rgb_t     left_shaft_rgb,
    input  logic                           right_shaft_hit,
    input  elevator_display_pkg::rgb_t     right_shaft_rgb,
    input  logic                           right_facade_hit,
    input  elevator_display_pkg::rgb_t     right_facade_rgb,
    output elevator_display_pkg::channel_t r,
    output elevator_display_pkg::channel_t g,
    output elevator_display_pkg::channel_t b
);
    import elevator_display_pkg::*;

    logic in_side_sky;
    logic in_top_sky;
    logic in_outline_rows;
    logic in_left_outline;
    logic in_mid_outline;
    logic in_right_outline;
    rgb_t pixel_rgb;
    rgb_t rgb_q;

    // Right strip stops at the grass line while the left one runs full height
    assign in_side_sky = (x_coord < SIDE_MARGIN)
                      || ((x_coord >= H_ACTIVE - SIDE_MARGIN) && (x_coord < H_ACTIVE)
                          && (y_coord < GROUND_ROW));

    assign in_top_sky      = (y_coord < TOP_MARGIN);
    assign in_outline_rows = (y_coord >= TOP_MARGIN) && (y_coord < GROUND_ROW);

    assign in_left_outline  = (x_coord >= LEFT_OUTLINE_LO) && (x_coord < LEFT_OUTLINE_HI)
                           && in_outline_rows;
    assign in_mid_outline   = (x_coord >= MID_OUTLINE_LO) && (x_coord < MID_OUTLINE_HI)
                           && in_outline_rows;
    assign in_right_outline = (x_coord >= RIGHT_OUTLINE_LO) && (x_coord < RIGHT_OUTLINE_HI)
                           && in_outline_rows;

    // First match wins
    always_comb begin
        if (!enable) begin
            pixel_rgb = BLACK_RGB;
        end else if (in_side_sky || in_top_sky) begin
            pixel_rgb = SKY_RGB;
        end else if (left_facade_hit) begin
            // Left facade runs over its outline and into the shaft
            pixel_rgb = left_facade_rgb;
        end else if (in_left_outline) begin
            pixel_rgb = OUTLINE_RGB;
        end else if (left_shaft_hit) begin
            pixel_rgb = left_shaft_rgb;
        end else if (in_mid_outline) begin
            pixel_rgb = OUTLINE_RGB;
        end else if (right_shaft_hit) begin
            pixel_rgb = right_shaft_rgb;
        end else if (in_right_outline) begin
            pixel_rgb = OUTLINE_RGB;
        end else if (right_facade_hit) begin
            pixel_rgb = right_facade_rgb;
        end else begin
            pixel_rgb = GRASS_RGB;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_q <= BLACK_RGB;
        end else begin
            rgb_q <= pixel_rgb;
        end
    end

    assign r = rgb_q[11:8];
    assign g = rgb_q[7:4];
    assign b = rgb_q[3:0];

    // Blanking reaches the pins one pixel later
    blank_is_black: assert property (
        @(posedge clk) disable iff (!rst_n)
        !enable |=> (r == 4'd0) && (g == 4'd0) && (b == 4'd0)
    ) else $error("scene_compositor output not black after blanking");

endmodule

//--- source/shaft_painter.sv
`timescale 1ns/10ps

module shaft_painter #(
    parameter elevator_display_pkg::coord_t X_LO = 10'd0,
    parameter elevator_display_pkg::coord_t X_HI = 10'd0
) (
    input  elevator_display_pkg::coord_t     x_coord,
    input  elevator_display_pkg::coord_t     y_coord,
    input  elevator_display_pkg::car_pos_t   car_pos,
    input  elevator_display_pkg::sim_state_e state,
    output logic                             hit,
    output elevator_display_pkg::rgb_t       rgb
);
    import elevator_display_pkg::*;

    car_pos_t clamped_pos;
    coord_t   car_top;
    logic     in_rows;
    logic     in_parked_car;
    logic     in_moving_car;
    logic     in_stop_sign;

    assign in_rows = (y_coord >= TOP_MARGIN) && (y_coord < GROUND_ROW);
    assign hit     = (x_coord >= X_LO) && (x_coord < X_HI) && in_rows;

    // Codes past the sixth floor stay at the sixth floor
    assign clamped_pos = (car_pos > MAX_CAR_POS) ? MAX_CAR_POS : car_pos;

    // Half a floor per step rounded down
    assign car_top = FIRST_FLOOR_CAR_TOP
                   - ((coord_t'(clamped_pos) * FLOOR_HEIGHT) >> 1);

    assign in_parked_car = (y_coord >= GROUND_ROW - PARKED_CAR_HEIGHT);

    assign in_moving_car = (y_coord >= car_top)
                        && (y_coord < car_top + CAR_HEIGHT);

    // Stop sign uses screen coordinates so only part of it lands in a shaft
    assign in_stop_sign = (x_coord >= STOP_X_LO) && (x_coord < STOP_X_HI)
                       && (y_coord >= STOP_Y_LO) && (y_coord < STOP_Y_HI);

    always_comb begin
        case (state)
            ST_PARKED: begin
                rgb = in_parked_car ? CAR_RGB : SHAFT_RGB;
            end
            ST_MOVING: begin
                rgb = in_moving_car ? CAR_RGB : SHAFT_RGB;
            end
            // Code 3 draws the same as a stop
            default: begin
                rgb = in_stop_sign ? STOP_RGB : BLACK_RGB;
            end
        endcase
    end

    // The moving car always fits between the top margin and the grass line
    always_comb begin
        car_in_shaft: assert ((car_top >= TOP_MARGIN)
                              && (car_top <= GROUND_ROW - CAR_HEIGHT))
            else $error("shaft_painter car top %0d outside the shaft rows", car_top);
    end

endmodule

//--- include/scene_model.svh
`ifndef SCENE_MODEL_SVH
`define SCENE_MODEL_SVH

// Expected colour inside one shaft in screen coordinates
function automatic elevator_display_pkg::rgb_t shaft_model_rgb(
    input int x,
    input int y,
    input int pos,
    input int state
);
    int top;
    int clamped;
    clamped = (pos > 10) ? 10 : pos;
    top     = 390 - (clamped * 75) / 2;
    if (state == 0) begin
        return (y >= 395) ? 12'h444 : 12'h841;
    end
    if (state == 1) begin
        return (y >= top && y < top + 75) ? 12'h444 : 12'h841;
    end
    // Stopped and code 3
    return (x >= 300 && x < 340 && y >= 200 && y < 260) ? 12'hF00 : 12'h000;
endfunction

// Whole scene before the output register
function automatic elevator_display_pkg::rgb_t scene_model_rgb(
    input logic       enable,
    input int         x,
    input int         y,
    input logic [7:0] destination,
    input logic [1:0] sim_state
);
    int band;
    bit in_rows;
    band    = (y - 15) / 75;
    in_rows = (y >= 15) && (y < 465);
    if (!enable) begin
        return 12'h000;
    end
    if (x < 20 || (x >= 620 && x < 640 && y < 465) || y < 15) begin
        return 12'h28F;
    end
    if ((x >= 20 && x < 210) || (x >= 405 && x < 620)) begin
        return (band == 0 || band == 2 || band == 4) ? 12'h9AA : 12'hBBB;
    end
    if (!in_rows) begin
        return 12'h0F0;
    end
    if ((x >= 195 && x < 205) || (x >= 295 && x < 305) || (x >= 395 && x < 405)) begin
        return 12'h000;
    end
    if (x >= 205 && x < 295) begin
        return shaft_model_rgb(x, y, int'(destination[7:4]), int'(sim_state));
    end
    if (x >= 305 && x < 395) begin
        return shaft_model_rgb(x, y, int'(destination[3:0]), int'(sim_state));
    end
    return 12'h0F0;
endfunction

`endif

//--- tb/elevator_display_tb.sv
`timescale 1ns/10ps

module elevator_display_tb;
    import elevator_display_pkg::*;

    `include "scene_model.svh"

    localparam int RESET_CYCLES  = 3;
    localparam int PARKED_PIXELS = 3000;
    localparam int SWEEP_ROWS    = 480;
    localparam int MOVING_PIXELS = 16 * 2 * SWEEP_ROWS;
    localparam int STOP_PIXELS   = 2 * 56 * 81;
    localparam int BLANK_PIXELS  = 2000;
    localparam int RANDOM_PIXELS = 20000;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + PARKED_PIXELS + MOVING_PIXELS
                                 + STOP_PIXELS + BLANK_PIXELS + RANDOM_PIXELS + 2;
    localparam int TIMEOUT_NS    = (TOTAL_CYCLES + 1000) * 10;

    logic       clk;
    logic       rst_n;
    logic       enable;
    coord_t     x_coord;
    coord_t     y_coord;
    logic [7:0] destination;
    logic [1:0] sim_state;
    channel_t   r;
    channel_t   g;
    channel_t   b;
    integer     seed;

    // Expectation for the pixel now in the output register
    logic       pending;
    logic       pending_en;
    rgb_t       pending_rgb;
    string      pending_name;

    elevator_display i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .x_coord     (x_coord),
        .y_coord     (y_coord),
        .destination (destination),
        .sim_state   (sim_state),
        .r           (r),
        .g           (g),
        .b           (b)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_channel(input string name, input channel_t expected,
                                 input channel_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %03h, actual %03h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic draw_random(output logic [31:0] value);
        value = $random(seed);
    endtask

    task automatic check_pending();
        if (pending) begin
            if (!pending_en) begin
                check_channel({pending_name, " red"}, 4'd0, r);
                check_channel({pending_name, " green"}, 4'd0, g);
                check_channel({pending_name, " blue"}, 4'd0, b);
            end
            check_rgb(pending_name, pending_rgb, {r, g, b});
        end
    endtask

    // One pixel per clock, checked on the following edge
    task automatic send_pixel(input string name, input logic en, input coord_t x,
                              input coord_t y, input logic [7:0] dest, input logic [1:0] st);
        @(posedge clk);
        #1;
        check_pending();
        enable       = en;
        x_coord      = x;
        y_coord      = y;
        destination  = dest;
        sim_state    = st;
        pending_rgb  = scene_model_rgb(en, int'(x), int'(y), dest, st);
        pending_en   = en;
        pending_name = name;
        pending      = 1'b1;
    endtask

    task automatic drain_pipeline();
        @(posedge clk);
        #1;
        check_pending();
        pending = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] rnd2;
        int          col;
        seed         = 32'h954ab6a0;
        rst_n        = 1'b0;
        enable       = 1'b1;
        x_coord      = '0;
        y_coord      = '0;
        destination  = '0;
        sim_state    = '0;
        pending      = 1'b0;
        pending_en   = 1'b1;
        pending_rgb  = '0;
        pending_name = "";

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_channel("reset red", 4'd0, r);
            check_channel("reset green", 4'd0, g);
            check_channel("reset blue", 4'd0, b);
        end
        rst_n = 1'b1;

        for (int i = 0; i < PARKED_PIXELS; i++) begin
            draw_random(rnd);
            send_pixel("parked", 1'b1, coord_t'(rnd[15:0] % 16'd640),
                       coord_t'(rnd[31:16] % 16'd480), rnd[23:16], 2'd0);
        end

        // Left car at pos, right car at 15 - pos, one column in each shaft
        for (int pos = 0; pos < 16; pos++) begin
            for (int s = 0; s < 2; s++) begin
                col = (s == 0) ? 250 : 350;
                for (int row = 0; row < SWEEP_ROWS; row++) begin
                    send_pixel("moving", 1'b1, coord_t'(col), coord_t'(row),
                               {4'(pos), 4'(15 - pos)}, 2'd1);
                end
            end
        end

        // Stop sign, its surround and the middle outline over it
        for (int st = 2; st < 4; st++) begin
            for (int x = 290; x < 346; x++) begin
                for (int y = 190; y < 271; y++) begin
                    draw_random(rnd);
                    send_pixel("stopped", 1'b1, coord_t'(x), coord_t'(y), rnd[7:0], 2'(st));
                end
            end
        end

        for (int i = 0; i < BLANK_PIXELS; i++) begin
            draw_random(rnd);
            draw_random(rnd2);
            send_pixel("blanking", rnd2[4], coord_t'(rnd[15:0] % 16'd640),
                       coord_t'(rnd[31:16] % 16'd480), rnd2[15:8], rnd2[17:16]);
        end

        for (int i = 0; i < RANDOM_PIXELS; i++) begin
            draw_random(rnd);
            send_pixel("random", rnd[31:30] != 2'b00, rnd[9:0], rnd[19:10],
                       rnd[27:20], rnd[29:28]);
        end

        drain_pipeline();
        $display("All tests passed!");
        $finish;
    end

endmodule
